//--- Bender.yml
package:
  name: vmem

sources:
  - hdl/vmem_pkg.sv
  - hdl/sched_if.sv
  - hdl/mem_req_if.sv
  - hdl/address_scheduler.sv
  - hdl/dmem_extender.sv
  - hdl/data_ram.sv
  - hdl/vmem_stage.sv
  - hdl/vmem_top.sv
  - target: test
    files:
      - bench/vmem_tb.sv

//--- bench/vmem_tb.sv
// vmem_tb: testbench for vmem_top with RAM shadow, reference model, compare process and watchdog
`timescale 1ns/1ns
`default_nettype none

module vmem_tb import vmem_pkg::*; ();

  localparam int RAM_DEPTH    = 256;
  localparam int RESET_CYCLES = 16;
  localparam int RESULT_WAIT  = 20;
  // fill stores, directed operations and random operations
  localparam int NUM_OPS      = RAM_DEPTH / 2 + 40 + 200;

  logic   CLK;
  logic   nRST;
  logic   start;
  op_t    op;
  sew_t   sew;
  word_t  addr0;
  word_t  addr1;
  word_t  data0;
  word_t  data1;
  logic   flush;
  logic   busy;
  logic   result_valid;
  word_t  result0;
  word_t  result1;
  logic   exception;

  word_t  shadow [RAM_DEPTH];
  integer seed;
  int     value_errors;
  int     other_errors;
  logic   pending;
  word_t  exp_r0;
  word_t  exp_r1;
  logic   exp_exc;

  vmem_top #(.RAM_DEPTH(RAM_DEPTH)) DUT (
    .CLK          (CLK),
    .nRST         (nRST),
    .start        (start),
    .op           (op),
    .sew          (sew),
    .addr0        (addr0),
    .addr1        (addr1),
    .data0        (data0),
    .data1        (data1),
    .flush        (flush),
    .busy         (busy),
    .result_valid (result_valid),
    .result0      (result0),
    .result1      (result1),
    .exception    (exception)
  );

  always #10 CLK = ~CLK;

  // initial RAM contents mixing every address bit
  function automatic word_t fill_word(input word_t a);
    return (a * 32'h9e37_79b9) ^ {a[15:0], a[31:16]};
  endfunction

  // odd halfword, word not on a 4-byte boundary, or past the last word
  function automatic logic addr_bad(input word_t a, input sew_t s);
    return (a[31:2] >= RAM_DEPTH) || (s == SEW16 && a[0]) || (s == SEW32 && a[1:0] != 2'd0);
  endfunction

  // zero-extended element as the shadow holds it
  function automatic word_t element(input word_t a, input sew_t s);
    word_t w;
    w = shadow[a[31:2]];
    case (s)
      SEW8:    return (w >> (8 * a[1:0])) & 32'h0000_00ff;
      SEW16:   return (w >> (8 * a[1:0])) & 32'h0000_ffff;
      default: return w;
    endcase
  endfunction

  function automatic void predict(input op_t o, input sew_t s, input word_t a0, input word_t a1,
                                  output word_t r0, output word_t r1, output logic exc);
    exc = 1'b0;
    r0  = '0;
    r1  = '0;
    if (o == OP_ALU) begin
      r0 = a0;
      r1 = a1;
    end else if (addr_bad(a0, s) || addr_bad(a1, s)) begin
      exc = 1'b1;
    end else if (o == OP_LOAD) begin
      r0 = element(a0, s);
      r1 = element(a1, s);
    end
  endfunction

  task automatic shadow_store(input word_t a, input word_t d, input sew_t s);
    int idx;
    idx = a[31:2];
    case (s)
      SEW8:    shadow[idx][8*a[1:0] +: 8]  = d[7:0];
      SEW16:   shadow[idx][8*a[1:0] +: 16] = d[15:0];
      default: shadow[idx] = d;
    endcase
  endtask

  // one operation, then wait for the compare process to see its result
  task automatic run_op(input op_t o, input sew_t s, input word_t a0, input word_t a1,
                        input word_t d0, input word_t d1);
    word_t r0;
    word_t r1;
    logic  exc;
    int    waited;
    predict(o, s, a0, a1, r0, r1, exc);
    @(negedge CLK);
    op      = o;
    sew     = s;
    addr0   = a0;
    addr1   = a1;
    data0   = d0;
    data1   = d1;
    start   = 1'b1;
    exp_r0  = r0;
    exp_r1  = r1;
    exp_exc = exc;
    pending = 1'b1;
    // lane 0 first, so lane 1 wins on a shared word
    if (o == OP_STORE && !exc) begin
      shadow_store(a0, d0, s);
      shadow_store(a1, d1, s);
    end
    @(negedge CLK);
    start  = 1'b0;
    // ALU result is due on the first cycle after start
    if (o == OP_ALU) begin
      assert (result_valid === 1'b1) else begin
        $display("ALU result_valid not high one cycle after start at %0t", $time);
        other_errors++;
      end
    end
    waited = 1;
    while (pending && waited < RESULT_WAIT) begin
      @(negedge CLK);
      waited++;
    end
    assert (!pending) else begin
      $display("no result_valid within %0d cycles of the operation before %0t", RESULT_WAIT,
               $time);
      other_errors++;
      pending = 1'b0;
    end
  endtask

  task automatic pick_addr(input sew_t s, output word_t a);
    int pick;
    pick = $unsigned($random(seed)) % 16;
    a    = ($unsigned($random(seed)) % RAM_DEPTH) * 4;
    if (pick == 0) begin
      a = a | ($unsigned($random(seed)) & 3);
    end else if (pick == 1) begin
      a = (RAM_DEPTH + $unsigned($random(seed)) % 64) * 4;
    end else if (s == SEW8) begin
      a = a + $unsigned($random(seed)) % 4;
    end else if (s == SEW16) begin
      a = a + ($unsigned($random(seed)) % 2) * 2;
    end
  endtask

  task automatic random_op();
    op_t   o;
    sew_t  s;
    word_t a0;
    word_t a1;
    case ($unsigned($random(seed)) % 3)
      0:       o = OP_ALU;
      1:       o = OP_LOAD;
      default: o = OP_STORE;
    endcase
    case ($unsigned($random(seed)) % 3)
      0:       s = SEW8;
      1:       s = SEW16;
      default: s = SEW32;
    endcase
    pick_addr(s, a0);
    pick_addr(s, a1);
    run_op(o, s, a0, a1, $random(seed), $random(seed));
  endtask

  // load flushed in its lane 0 wait must give no result
  task automatic flush_load(input word_t a0, input word_t a1);
    @(negedge CLK);
    op    = OP_LOAD;
    sew   = SEW32;
    addr0 = a0;
    addr1 = a1;
    start = 1'b1;
    @(negedge CLK);
    start = 1'b0;
    @(negedge CLK);
    flush = 1'b1;
    @(negedge CLK);
    flush = 1'b0;
    repeat (8) @(negedge CLK);
    assert (busy === 1'b0) else begin
      $display("busy still high eight cycles after flush");
      other_errors++;
    end
  endtask

  // compare process
  always @(negedge CLK) begin
    if (nRST && result_valid) begin
      assert (pending) else begin
        $display("result_valid at %0t with no operation outstanding", $time);
        other_errors++;
      end
      if (pending) begin
        assert (exception === exp_exc) else begin
          $display("Fail %0t: exception %b, expected %b", $time, exception, exp_exc);
          value_errors++;
        end
        assert (result0 === exp_r0) else begin
          $display("Fail %0t: result0 %h, expected %h", $time, result0, exp_r0);
          value_errors++;
        end
        assert (result1 === exp_r1) else begin
          $display("Fail %0t: result1 %h, expected %h", $time, result1, exp_r1);
          value_errors++;
        end
      end
      pending = 1'b0;
    end
  end

  initial begin
    #(RESET_CYCLES * 20 + NUM_OPS * RESULT_WAIT * 20);
    $display("watchdog expired before the test sequence finished");
    $display("errors: %0d value, %0d other", value_errors, other_errors);
    $display("TEST FAIL");
    $finish;
  end

  initial begin
    word_t d0;
    word_t d1;
    CLK          = 1'b0;
    nRST         = 1'b0;
    start        = 1'b0;
    flush        = 1'b0;
    op           = OP_ALU;
    sew          = SEW8;
    addr0        = '0;
    addr1        = '0;
    data0        = '0;
    data1        = '0;
    seed         = 32'h1cbb_d88d;
    value_errors = 0;
    other_errors = 0;
    pending      = 1'b0;
    repeat (RESET_CYCLES) @(negedge CLK);
    assert (busy === 1'b0 && result_valid === 1'b0 && exception === 1'b0) else begin
      $display("busy, result_valid or exception not low in reset");
      other_errors++;
    end
    nRST = 1'b1;
    for (int w = 0; w < RAM_DEPTH; w += 2) begin
      run_op(OP_STORE, SEW32, w * 4, (w + 1) * 4, fill_word(w * 4), fill_word((w + 1) * 4));
    end
    repeat (4) begin
      run_op(OP_ALU, SEW32, $random(seed), $random(seed), 0, 0);
    end
    d0 = $random(seed);
    d1 = $random(seed);
    run_op(OP_STORE, SEW32, 80, 84, d0, d1);
    run_op(OP_LOAD, SEW32, 80, 84, 0, 0);
    // byte and halfword stores, then every legal offset
    run_op(OP_STORE, SEW8, 161, 167, $random(seed), $random(seed));
    run_op(OP_STORE, SEW16, 170, 172, $random(seed), $random(seed));
    for (int k = 0; k < 4; k++) begin
      run_op(OP_LOAD, SEW8, 160 + k, 164 + k, 0, 0);
      run_op(OP_LOAD, SEW8, 168 + k, 172 + k, 0, 0);
    end
    for (int k = 0; k < 4; k += 2) begin
      run_op(OP_LOAD, SEW16, 160 + k, 164 + k, 0, 0);
      run_op(OP_LOAD, SEW16, 168 + k, 172 + k, 0, 0);
    end
    run_op(OP_LOAD, SEW32, 160, 164, 0, 0);
    run_op(OP_LOAD, SEW32, 168, 172, 0, 0);
    // faults, then the words they would have hit
    run_op(OP_STORE, SEW16, 201, 204, $random(seed), $random(seed));
    run_op(OP_STORE, SEW32, 210, 216, $random(seed), $random(seed));
    run_op(OP_STORE, SEW8, 220, RAM_DEPTH * 4 + 8, $random(seed), $random(seed));
    run_op(OP_LOAD, SEW32, RAM_DEPTH * 4, 0, 0, 0);
    run_op(OP_LOAD, SEW32, 200, 204, 0, 0);
    run_op(OP_LOAD, SEW32, 208, 216, 0, 0);
    run_op(OP_LOAD, SEW32, 220, 8, 0, 0);
    flush_load(240, 244);
    run_op(OP_LOAD, SEW16, 242, 246, 0, 0);
    for (int n = 0; n < 200; n++) begin
      random_op();
    end
    repeat (4) @(negedge CLK);
    $display("errors: %0d value, %0d other", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- hdl/address_scheduler.sv
// address_scheduler: two-lane RAM access sequencer with alignment and range check
`timescale 1ns/1ns
`default_nettype none

module address_scheduler import vmem_pkg::*; #(
  parameter int RAM_DEPTH = 256
) (
  input logic      CLK,
  input logic      nRST,
  sched_if.sched   sched,
  mem_req_if.sched mem
);

  localparam logic [2:0] S_IDLE    = 3'd0;
  localparam logic [2:0] S_L0_REQ  = 3'd1;
  localparam logic [2:0] S_L0_WAIT = 3'd2;
  localparam logic [2:0] S_L1_REQ  = 3'd3;
  localparam logic [2:0] S_L1_WAIT = 3'd4;
  localparam logic [2:0] S_FAULT   = 3'd5;

  logic [2:0] state;
  logic [2:0] state_next;
  logic       is_store;
  logic       start_fault;
  logic       lane1;
  logic       req;
  logic       wait_hit;
  word_t      addr0_q;
  word_t      addr1_q;
  word_t      sdata0_q;
  word_t      sdata1_q;

  // misaligned for the width, or past the last RAM word
  function automatic logic addr_fault(input word_t a, input sew_t s);
    logic misaligned;
    case (s)
      SEW16:   misaligned = a[0];
      SEW32:   misaligned = |a[1:0];
      default: misaligned = 1'b0;
    endcase
    return misaligned | (a[31:2] >= RAM_DEPTH);
  endfunction

  function automatic logic [3:0] lane_mask(input logic [1:0] lo, input sew_t s);
    case (s)
      SEW32:   return 4'b1111;
      SEW16:   return 4'b0011 << {lo[1], 1'b0};
      default: return 4'b0001 << lo;
    endcase
  endfunction

  // op and sew are held by the stage while busy
  assign is_store    = (sched.op == OP_STORE);
  assign start_fault = addr_fault(sched.addr0, sched.sew) | addr_fault(sched.addr1, sched.sew);

  always_comb begin
    state_next = state;
    case (state)
      S_IDLE:    if (sched.start) state_next = start_fault ? S_FAULT : S_L0_REQ;
      S_L0_REQ:  state_next = S_L0_WAIT;
      S_L0_WAIT: if (mem.dhit) state_next = S_L1_REQ;
      S_L1_REQ:  state_next = S_L1_WAIT;
      S_L1_WAIT: if (mem.dhit) state_next = S_IDLE;
      default:   state_next = S_IDLE;
    endcase
    if (sched.flush) begin
      state_next = S_IDLE;
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state <= S_IDLE;
    end else begin
      state <= state_next;
    end
  end

  // lane addresses and replicated store data
  always_ff @(posedge CLK) begin
    if (state == S_IDLE && sched.start) begin
      addr0_q  <= sched.addr0;
      addr1_q  <= sched.addr1;
      sdata0_q <= sched.storedata0;
      sdata1_q <= sched.storedata1;
    end
  end

  assign lane1    = (state == S_L1_REQ) || (state == S_L1_WAIT);
  assign req      = (state == S_L0_REQ) || (state == S_L1_REQ);
  assign wait_hit = ((state == S_L0_WAIT) || (state == S_L1_WAIT)) && mem.dhit;

  assign mem.ren      = req & ~is_store;
  assign mem.wen      = req & is_store;
  assign mem.addr     = lane1 ? addr1_q : addr0_q;
  assign mem.wdata    = lane1 ? sdata1_q : sdata0_q;
  assign mem.byte_ena = lane_mask(mem.addr[1:0], sched.sew);

  assign sched.busy       = (state != S_IDLE);
  assign sched.arrived0   = (state == S_L0_WAIT) && mem.dhit && !is_store;
  assign sched.arrived1   = (state == S_L1_WAIT) && mem.dhit && !is_store;
  assign sched.store_done = wait_hit & is_store;
  assign sched.exception  = (state == S_FAULT);
  assign sched.lane_addr  = mem.addr[1:0];

endmodule

`default_nettype wire

//--- hdl/data_ram.sv
// data_ram: word RAM with byte write enables, registered read and hit pulse
`timescale 1ns/1ns
`default_nettype none

module data_ram import vmem_pkg::*; #(
  parameter int RAM_DEPTH = 256
) (
  input logic    CLK,
  input logic    nRST,
  mem_req_if.ram mem
);

  localparam int AW = $clog2(RAM_DEPTH);

  word_t          ram [RAM_DEPTH];
  logic [AW-1:0]  idx;

  // byte address in, word index out
  assign idx = mem.addr[AW+1:2];

  always_ff @(posedge CLK) begin
    if (mem.wen) begin
      for (int i = 0; i < 4; i++) begin
        if (mem.byte_ena[i]) begin
          ram[idx][8*i +: 8] <= mem.wdata[8*i +: 8];
        end
      end
    end
    if (mem.ren) begin
      mem.rdata <= ram[idx];
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      mem.dhit <= 1'b0;
    end else begin
      mem.dhit <= mem.ren | mem.wen;
    end
  end

endmodule

`default_nettype wire

//--- hdl/dmem_extender.sv
// dmem_extender: byte or halfword lane select with zero extension
`timescale 1ns/1ns
`default_nettype none

module dmem_extender import vmem_pkg::*; (
  input  word_t      dmem_in,
  input  sew_t       sew,
  input  logic [1:0] lane_addr,
  output word_t      ext_out
);

  mem_word_u word_view;

  assign word_view = dmem_in;

  always_comb begin
    case (sew)
      SEW8: begin
        ext_out = {24'd0, word_view.bytes[lane_addr]};
      end
      SEW16: begin
        // upper halfword when bit 1 of the address is set
        ext_out = {16'd0, word_view.halves[lane_addr[1]]};
      end
      default: begin
        ext_out = dmem_in;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- hdl/mem_req_if.sv
// mem_req_if: single-port data RAM request and response signals
`timescale 1ns/1ns
`default_nettype none

interface mem_req_if import vmem_pkg::*; ();

  logic       ren;
  logic       wen;
  word_t      addr;
  word_t      wdata;
  logic [3:0] byte_ena;

  // response, dhit one cycle after ren or wen
  word_t      rdata;
  logic       dhit;

  modport sched (
    output ren, wen, addr, wdata, byte_ena,
    input  rdata, dhit
  );

  modport ram (
    input  ren, wen, addr, wdata, byte_ena,
    output rdata, dhit
  );

endinterface

`default_nettype wire

//--- hdl/sched_if.sv
// sched_if: request and status signals between the memory stage and the address scheduler
`timescale 1ns/1ns
`default_nettype none

interface sched_if import vmem_pkg::*; ();

  // stage to scheduler
  logic       start;
  op_t        op;
  sew_t       sew;
  word_t      addr0;
  word_t      addr1;
  word_t      storedata0;
  word_t      storedata1;
  logic       flush;

  // scheduler to stage
  logic       busy;
  logic       arrived0;
  logic       arrived1;
  logic       store_done;
  logic       exception;
  logic [1:0] lane_addr;

  modport stage (
    output start, op, sew, addr0, addr1, storedata0, storedata1, flush,
    input  busy, arrived0, arrived1, store_done, exception, lane_addr
  );

  modport sched (
    input  start, op, sew, addr0, addr1, storedata0, storedata1, flush,
    output busy, arrived0, arrived1, store_done, exception, lane_addr
  );

endinterface

`default_nettype wire

//--- hdl/vmem_pkg.sv
// vmem_pkg: data word, element width, operation kind and RAM word view types
`default_nettype none

package vmem_pkg;

  // one RAM or register word
  typedef logic [31:0] word_t;

  // element width of the operation
  typedef enum logic [1:0] {
    SEW8  = 2'd0,
    SEW16 = 2'd1,
    SEW32 = 2'd2
  } sew_t;

  // kind of vector operation reaching the memory stage
  typedef enum logic [1:0] {
    OP_ALU   = 2'd0,
    OP_LOAD  = 2'd1,
    OP_STORE = 2'd2
  } op_t;

  // one RAM word, read as byte lanes for SEW8 or halfword lanes for SEW16
  typedef union packed {
    logic [3:0][7:0]  bytes;
    logic [1:0][15:0] halves;
  } mem_word_u;

endpackage

`default_nettype wire

//--- hdl/vmem_stage.sv
// vmem_stage: operation capture, store replication, load buffer and result latch
`timescale 1ns/1ns
`default_nettype none

module vmem_stage import vmem_pkg::*; (
  input  logic    CLK,
  input  logic    nRST,
  input  logic    start,
  input  logic    flush,
  input  op_t     op,
  input  sew_t    sew,
  input  word_t   addr0,
  input  word_t   addr1,
  input  word_t   data0,
  input  word_t   data1,
  sched_if.stage  sched,
  input  word_t   ext_data,
  output logic    result_valid,
  output logic    exception,
  output word_t   result0,
  output word_t   result1
);

  op_t   op_q;
  sew_t  sew_q;
  logic  accept;
  logic  alu_go;
  logic  st_lane1;
  word_t load_buf;

  // copy the element across the word so any byte lane can be written
  function automatic word_t replicate(input word_t d, input sew_t s);
    mem_word_u u;
    case (s)
      SEW8:    u.bytes  = {4{d[7:0]}};
      SEW16:   u.halves = {2{d[15:0]}};
      default: u        = d;
    endcase
    return u;
  endfunction

  assign accept = start & ~sched.busy;
  assign alu_go = accept & (op == OP_ALU);

  assign sched.start      = accept & (op != OP_ALU);
  assign sched.flush      = flush;
  assign sched.addr0      = addr0;
  assign sched.addr1      = addr1;
  assign sched.storedata0 = replicate(data0, sew);
  assign sched.storedata1 = replicate(data1, sew);
  // live values at start, held ones for the rest of the access
  assign sched.op         = sched.busy ? op_q : op;
  assign sched.sew        = sched.busy ? sew_q : sew;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      op_q     <= OP_ALU;
      sew_q    <= SEW8;
      st_lane1 <= 1'b0;
    end else if (flush) begin
      st_lane1 <= 1'b0;
    end else if (sched.start) begin
      op_q     <= op;
      sew_q    <= sew;
      st_lane1 <= 1'b0;
    end else if (sched.store_done) begin
      // second store_done belongs to lane 1
      st_lane1 <= 1'b1;
    end
  end

  // lane 0 load element waits here for lane 1
  always_ff @(posedge CLK) begin
    if (sched.arrived0) begin
      load_buf <= ext_data;
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      result_valid <= 1'b0;
      exception    <= 1'b0;
      result0      <= '0;
      result1      <= '0;
    end else if (flush) begin
      result_valid <= 1'b0;
      exception    <= 1'b0;
      result0      <= '0;
      result1      <= '0;
    end else begin
      result_valid <= 1'b0;
      exception    <= 1'b0;
      if (alu_go) begin
        result_valid <= 1'b1;
        result0      <= addr0;
        result1      <= addr1;
      end else if (sched.exception) begin
        result_valid <= 1'b1;
        exception    <= 1'b1;
        result0      <= '0;
        result1      <= '0;
      end else if (sched.arrived1 && op_q == OP_LOAD) begin
        result_valid <= 1'b1;
        result0      <= load_buf;
        result1      <= ext_data;
      end else if (sched.store_done && st_lane1 && op_q == OP_STORE) begin
        result_valid <= 1'b1;
        result0      <= '0;
        result1      <= '0;
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/vmem_top.sv
// vmem_top: memory stage, address scheduler, load extender and data RAM
`timescale 1ns/1ns
`default_nettype none

module vmem_top import vmem_pkg::*; #(
  parameter int RAM_DEPTH = 256
) (
  input  logic  CLK,
  input  logic  nRST,
  input  logic  start,
  input  op_t   op,
  input  sew_t  sew,
  input  word_t addr0,
  input  word_t addr1,
  input  word_t data0,
  input  word_t data1,
  input  logic  flush,
  output logic  busy,
  output logic  result_valid,
  output word_t result0,
  output word_t result1,
  output logic  exception
);

  word_t ext_data;

  sched_if   sched_bus ();
  mem_req_if mem_bus ();

  assign busy = sched_bus.busy;

  vmem_stage u_stage (
    .CLK          (CLK),
    .nRST         (nRST),
    .start        (start),
    .flush        (flush),
    .op           (op),
    .sew          (sew),
    .addr0        (addr0),
    .addr1        (addr1),
    .data0        (data0),
    .data1        (data1),
    .sched        (sched_bus.stage),
    .ext_data     (ext_data),
    .result_valid (result_valid),
    .exception    (exception),
    .result0      (result0),
    .result1      (result1)
  );

  address_scheduler #(.RAM_DEPTH(RAM_DEPTH)) u_sched (
    .CLK   (CLK),
    .nRST  (nRST),
    .sched (sched_bus.sched),
    .mem   (mem_bus.sched)
  );

  // read data is extracted with the held width and the served lane's offset
  dmem_extender u_ext (
    .dmem_in   (mem_bus.rdata),
    .sew       (sched_bus.sew),
    .lane_addr (sched_bus.lane_addr),
    .ext_out   (ext_data)
  );

  data_ram #(.RAM_DEPTH(RAM_DEPTH)) u_ram (
    .CLK  (CLK),
    .nRST (nRST),
    .mem  (mem_bus.ram)
  );

endmodule

`default_nettype wire

//--- vmem_top.f
hdl/vmem_pkg.sv
hdl/sched_if.sv
hdl/mem_req_if.sv
hdl/address_scheduler.sv
hdl/dmem_extender.sv
hdl/data_ram.sv
hdl/vmem_stage.sv
hdl/vmem_top.sv
bench/vmem_tb.sv
